// ==== hw/lane_defines.svh ====
// Lane sizing macros: element width, register count, elements per lane, immediate width

`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

// Width of one vector element in bits
`define LANE_DATA_WIDTH 32

// Architectural vector registers
`define LANE_REG_NUM 32

// Elements of each register held in this lane
`define LANE_ELEMS 4

// Immediate field and register specifier width
`define LANE_IMM_WIDTH 5

`endif

// ==== hw/lane_pkg.sv ====
// Lane package: instruction encodings, instruction struct, stage payload types

`include "lane_defines.svh"

package lane_pkg;

  // Operand form, RVV funct3 encoding
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_t;

  // Integer operations, RVV funct6 encoding
  typedef enum logic [5:0] {
    VADD  = 6'b000000,
    VSUB  = 6'b000010,
    VRSUB = 6'b000011,
    VMINU = 6'b000100,
    VMAXU = 6'b000110,
    VAND  = 6'b001001,
    VOR   = 6'b001010,
    VXOR  = 6'b001011,
    VMV   = 6'b010111
  } funct6_t;

  typedef logic [`LANE_DATA_WIDTH-1:0]       data_t;
  typedef logic [$clog2(`LANE_ELEMS)-1:0]    elem_idx_t;
  typedef logic [$clog2(`LANE_REG_NUM)-1:0]  reg_addr_t;

  // 25-bit arithmetic instruction
  typedef struct packed {
    funct6_t                     funct6;
    logic                        vm;
    reg_addr_t                   vs2;
    logic [`LANE_IMM_WIDTH-1:0]  vs1_imm;
    funct3_t                     funct3;
    reg_addr_t                   vd;
  } instr_t;

  // Read to execute
  typedef struct packed {
    funct6_t    funct6;
    reg_addr_t  vd;
    elem_idx_t  elem;
    logic       en;
    logic       last;
    data_t      a;
    data_t      b;
  } ex_payload_t;

  // Execute to writeback
  typedef struct packed {
    reg_addr_t  vd;
    elem_idx_t  elem;
    logic       en;
    logic       last;
    data_t      result;
  } wb_payload_t;

endpackage

// ==== hw/lane_stage_if.sv ====
// Stage-link interface with payload type parameter and register-file write interface

`timescale 1ns/1ps

// One element per valid cycle, no back-pressure
interface lane_stage_if #(
  parameter type payload_t = logic
);
  logic      valid;
  payload_t  payload;

  modport src (output valid, output payload);
  modport dst (input valid, input payload);
endinterface

// Element write port of the lane register file
interface lane_vrf_wr_if;
  import lane_pkg::*;

  logic       wr_en;
  reg_addr_t  addr;
  elem_idx_t  elem;
  data_t      data;

  modport wr (output wr_en, output addr, output elem, output data);
  modport rf (input wr_en, input addr, input elem, input data);
endinterface

// ==== hw/lane_issue.sv ====
// Read stage: instruction accept, element counter, register reads, operand select

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_issue (
  input  logic                     clk_i,
  input  logic                     resetn_i,
  input  logic                     instr_valid_i,
  input  lane_pkg::instr_t         instr_i,
  input  lane_pkg::data_t          rs1_i,
  input  logic [`LANE_ELEMS-1:0]   mask_bits_i,
  input  logic                     done_i,
  output logic                     ready_o,
  output lane_pkg::reg_addr_t      rd_addr_a_o,
  output lane_pkg::reg_addr_t      rd_addr_b_o,
  output lane_pkg::elem_idx_t      rd_elem_o,
  input  lane_pkg::data_t          rd_data_a_i,
  input  lane_pkg::data_t          rd_data_b_i,
  lane_stage_if.src                ex_o
);
  import lane_pkg::*;

  instr_t                  instr_q;
  data_t                   rs1_q;
  logic [`LANE_ELEMS-1:0]  mask_q;
  logic                    busy_q;
  logic                    rd_active_q;
  elem_idx_t               elem_cnt_q;
  logic                    accept;
  logic                    last_elem;
  ex_payload_t             ex_d;

  assign ready_o   = ~busy_q;
  assign accept    = instr_valid_i & ready_o;
  assign last_elem = (elem_cnt_q == elem_idx_t'(`LANE_ELEMS - 1));

  ////////////////////////////////////////
  // Instruction hold
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_q <= instr_i;
      rs1_q   <= rs1_i;
      mask_q  <= mask_bits_i;
    end
  end

  // Busy until writeback reports the last element
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      busy_q      <= 1'b0;
      rd_active_q <= 1'b0;
      elem_cnt_q  <= '0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      if (accept) begin
        rd_active_q <= 1'b1;
        elem_cnt_q  <= '0;
      end else if (rd_active_q) begin
        rd_active_q <= ~last_elem;
        elem_cnt_q  <= last_elem ? '0 : elem_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Register reads and operand select
  ////////////////////////////////////////

  assign rd_addr_a_o = instr_q.vs1_imm;
  assign rd_addr_b_o = instr_q.vs2;
  assign rd_elem_o   = elem_cnt_q;

  always_comb begin
    ex_d.funct6 = instr_q.funct6;
    ex_d.vd     = instr_q.vd;
    ex_d.elem   = elem_cnt_q;
    // vm set means unmasked
    ex_d.en     = instr_q.vm | mask_q[elem_cnt_q];
    ex_d.last   = last_elem;
    ex_d.b      = rd_data_b_i;
    case (instr_q.funct3)
      OPIVX:   ex_d.a = rs1_q;
      OPIVI:   ex_d.a = {{(`LANE_DATA_WIDTH - `LANE_IMM_WIDTH){1'b0}}, instr_q.vs1_imm};
      default: ex_d.a = rd_data_a_i;
    endcase
  end

  // Into execute at the end of the read cycle
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      ex_o.valid <= 1'b0;
    end else begin
      ex_o.valid <= rd_active_q;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_o.payload <= ex_d;
  end

endmodule

// ==== hw/lane_vrf.sv ====
// Lane vector register file: two combinational read ports, one element write port

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_vrf (
  input  logic                 clk_i,
  input  logic                 resetn_i,
  input  lane_pkg::reg_addr_t  rd_addr_a_i,
  input  lane_pkg::reg_addr_t  rd_addr_b_i,
  input  lane_pkg::elem_idx_t  rd_elem_i,
  output lane_pkg::data_t      rd_data_a_o,
  output lane_pkg::data_t      rd_data_b_o,
  lane_vrf_wr_if.rf            wr_i
);
  import lane_pkg::*;

  // Register by element
  data_t regs_q [`LANE_REG_NUM][`LANE_ELEMS];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      for (int r = 0; r < `LANE_REG_NUM; r++) begin
        for (int e = 0; e < `LANE_ELEMS; e++) begin
          regs_q[r][e] <= '0;
        end
      end
    end else if (wr_i.wr_en) begin
      regs_q[wr_i.addr][wr_i.elem] <= wr_i.data;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Same element for both operands
  assign rd_data_a_o = regs_q[rd_addr_a_i][rd_elem_i];
  assign rd_data_b_o = regs_q[rd_addr_b_i][rd_elem_i];

endmodule

// ==== hw/lane_alu.sv ====
// Execute stage: integer ALU operations and execute pipeline register

`timescale 1ns/1ps

module lane_alu (
  input  logic       clk_i,
  input  logic       resetn_i,
  lane_stage_if.dst  ex_i,
  lane_stage_if.src  wb_o
);
  import lane_pkg::*;

  ex_payload_t  ex;
  data_t        result;
  wb_payload_t  wb_d;

  assign ex = ex_i.payload;

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////

  // a is vs1, scalar or immediate; b is vs2
  always_comb begin
    case (ex.funct6)
      VADD:    result = ex.b + ex.a;
      VSUB:    result = ex.b - ex.a;
      VRSUB:   result = ex.a - ex.b;
      VAND:    result = ex.b & ex.a;
      VOR:     result = ex.b | ex.a;
      VXOR:    result = ex.b ^ ex.a;
      VMINU:   result = (ex.a < ex.b) ? ex.a : ex.b;
      VMAXU:   result = (ex.a > ex.b) ? ex.a : ex.b;
      VMV:     result = ex.a;
      default: result = ex.a;
    endcase
  end

  always_comb begin
    wb_d.vd     = ex.vd;
    wb_d.elem   = ex.elem;
    wb_d.en     = ex.en;
    wb_d.last   = ex.last;
    wb_d.result = result;
  end

  // One cycle of latency
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      wb_o.valid <= 1'b0;
    end else begin
      wb_o.valid <= ex_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_o.payload <= wb_d;
  end

endmodule

// ==== hw/lane_writeback.sv ====
// Writeback stage: masked register write, set-bit count, instruction completion

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_writeback (
  input  logic                             clk_i,
  input  logic                             resetn_i,
  lane_stage_if.dst                        wb_i,
  lane_vrf_wr_if.wr                        vrf_o,
  output logic                             done_o,
  output logic [$clog2(`LANE_DATA_WIDTH):0] sbit_cnt_o
);
  import lane_pkg::*;

  localparam int cnt_width = $clog2(`LANE_DATA_WIDTH) + 1;

  wb_payload_t  wb;
  logic         wr_en;

  assign wb = wb_i.payload;

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  // Disabled elements keep their old value
  assign wr_en = wb_i.valid & wb.en;

  assign vrf_o.wr_en = wr_en;
  assign vrf_o.addr  = wb.vd;
  assign vrf_o.elem  = wb.elem;
  assign vrf_o.data  = wb.result;

  // Last element ends the instruction even when masked off
  assign done_o = wb_i.valid & wb.last;

  ////////////////////////////////////////
  // Set-bit count
  ////////////////////////////////////////

  // Held between writes
  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      sbit_cnt_o <= '0;
    end else if (wr_en) begin
      sbit_cnt_o <= cnt_width'($countones(wb.result));
    end
  end

endmodule

// ==== hw/lane_top.sv ====
// Lane top level: read, execute and writeback stages around the register file

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_top (
  input  logic                              clk_i,
  input  logic                              resetn_i,
  input  logic                              instr_valid_i,
  input  lane_pkg::instr_t                  instr_i,
  input  lane_pkg::data_t                   rs1_i,
  input  logic [`LANE_ELEMS-1:0]            mask_bits_i,
  output logic                              ready_o,
  output logic                              vd_wr_en_o,
  output lane_pkg::reg_addr_t               vd_addr_o,
  output lane_pkg::elem_idx_t               vd_elem_o,
  output lane_pkg::data_t                   vd_wdata_o,
  output logic [$clog2(`LANE_DATA_WIDTH):0] sbit_cnt_o
);
  import lane_pkg::*;

  reg_addr_t  rd_addr_a;
  reg_addr_t  rd_addr_b;
  elem_idx_t  rd_elem;
  data_t      rd_data_a;
  data_t      rd_data_b;
  logic       done;

  ////////////////////////////////////////
  // Stage links
  ////////////////////////////////////////

  lane_stage_if #(.payload_t(ex_payload_t)) ex_link ();
  lane_stage_if #(.payload_t(wb_payload_t)) wb_link ();
  lane_vrf_wr_if                            vrf_wr ();

  lane_issue u_issue (
    .clk_i         (clk_i),
    .resetn_i      (resetn_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_i         (rs1_i),
    .mask_bits_i   (mask_bits_i),
    .done_i        (done),
    .ready_o       (ready_o),
    .rd_addr_a_o   (rd_addr_a),
    .rd_addr_b_o   (rd_addr_b),
    .rd_elem_o     (rd_elem),
    .rd_data_a_i   (rd_data_a),
    .rd_data_b_i   (rd_data_b),
    .ex_o          (ex_link.src)
  );

  lane_vrf u_vrf (
    .clk_i       (clk_i),
    .resetn_i    (resetn_i),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_elem_i   (rd_elem),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .wr_i        (vrf_wr.rf)
  );

  lane_alu u_alu (
    .clk_i    (clk_i),
    .resetn_i (resetn_i),
    .ex_i     (ex_link.dst),
    .wb_o     (wb_link.src)
  );

  lane_writeback u_writeback (
    .clk_i      (clk_i),
    .resetn_i   (resetn_i),
    .wb_i       (wb_link.dst),
    .vrf_o      (vrf_wr.wr),
    .done_o     (done),
    .sbit_cnt_o (sbit_cnt_o)
  );

  // Writeback trace
  assign vd_wr_en_o = vrf_wr.wr_en;
  assign vd_addr_o  = vrf_wr.addr;
  assign vd_elem_o  = vrf_wr.elem;
  assign vd_wdata_o = vrf_wr.data;

endmodule

// ==== tb/lane_checker.sv ====
// Bound assertions on the lane top-level ports: write strobe, busy window, set-bit count range

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_checker (
  input logic                              clk_i,
  input logic                              resetn_i,
  input logic                              instr_valid_i,
  input logic                              ready_i,
  input logic                              vd_wr_en_i,
  input logic [$clog2(`LANE_DATA_WIDTH):0] sbit_cnt_i
);

  // Cycles since the last acceptance, 0 when idle
  logic [2:0] since_accept_q;

  // Assertion failures so far
  int fail_cnt = 0;

  always_ff @(posedge clk_i or negedge resetn_i) begin
    if (!resetn_i) begin
      since_accept_q <= '0;
    end else if (instr_valid_i && ready_i) begin
      since_accept_q <= 3'd1;
    end else if (since_accept_q == 3'd7) begin
      since_accept_q <= '0;
    end else if (since_accept_q != '0) begin
      since_accept_q <= since_accept_q + 3'd1;
    end
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  a_write_while_busy: assert property (
    @(posedge clk_i) disable iff (!resetn_i) vd_wr_en_i |-> !ready_i
  ) else begin
    $error("write strobe seen while ready_o is high");
    fail_cnt++;
  end

  // Six busy cycles, then ready again
  a_busy_window: assert property (
    @(posedge clk_i) disable iff (!resetn_i)
      (since_accept_q != 3'd0 && since_accept_q < 3'd7) |-> !ready_i
  ) else begin
    $error("ready_o high inside the busy window");
    fail_cnt++;
  end

  a_ready_return: assert property (
    @(posedge clk_i) disable iff (!resetn_i) (since_accept_q == 3'd7) |-> ready_i
  ) else begin
    $error("ready_o not back after six busy cycles");
    fail_cnt++;
  end

  a_sbit_range: assert property (
    @(posedge clk_i) disable iff (!resetn_i) sbit_cnt_i <= `LANE_DATA_WIDTH
  ) else begin
    $error("set-bit count above the data width");
    fail_cnt++;
  end

  // Count only moves in the cycle after a write
  a_sbit_hold: assert property (
    @(posedge clk_i) disable iff (!resetn_i) !vd_wr_en_i |=> $stable(sbit_cnt_i)
  ) else begin
    $error("set-bit count changed without a write");
    fail_cnt++;
  end

endmodule

// ==== tb/lane_monitor.sv ====
// Lane monitor: reference register-file model, expected write queue, write and set-bit checks

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_monitor (
  input  logic                              clk_i,
  input  logic                              resetn_i,
  input  logic                              instr_valid_i,
  input  lane_pkg::instr_t                  instr_i,
  input  lane_pkg::data_t                   rs1_i,
  input  logic [`LANE_ELEMS-1:0]            mask_bits_i,
  input  logic                              ready_i,
  input  logic                              vd_wr_en_i,
  input  lane_pkg::reg_addr_t               vd_addr_i,
  input  lane_pkg::elem_idx_t               vd_elem_i,
  input  lane_pkg::data_t                   vd_wdata_i,
  input  logic [$clog2(`LANE_DATA_WIDTH):0] sbit_cnt_i,
  input  logic [8*12-1:0]                   test_name_i,
  output int                                err_cnt_o,
  output int                                pending_o,
  output int                                wr_cnt_o
);
  import lane_pkg::*;

  typedef struct packed {
    reg_addr_t  addr;
    elem_idx_t  elem;
    data_t      data;
  } exp_wr_t;

  data_t           model_q [`LANE_REG_NUM][`LANE_ELEMS];
  exp_wr_t         exp_q [$];
  logic [8*12-1:0] cur_name;
  logic            sbit_due = 1'b0;
  int              sbit_exp = 0;
  int              errors = 0;
  int              pending = 0;
  int              writes = 0;

  assign err_cnt_o = errors;
  assign pending_o = pending;
  assign wr_cnt_o  = writes;

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  // op1 is vs1 data, scalar or immediate; vs2 is the second source
  function automatic data_t expected_result(funct6_t op, data_t op1, data_t vs2);
    data_t smaller;
    data_t larger;
    if (op1 <= vs2) begin
      smaller = op1;
      larger  = vs2;
    end else begin
      smaller = vs2;
      larger  = op1;
    end
    case (op)
      VADD:    return op1 + vs2;
      VSUB:    return vs2 - op1;
      VRSUB:   return op1 - vs2;
      VAND:    return op1 & vs2;
      VOR:     return op1 | vs2;
      VXOR:    return op1 ^ vs2;
      VMINU:   return smaller;
      VMAXU:   return larger;
      VMV:     return op1;
      default: return 'x;
    endcase
  endfunction

  function automatic int count_ones(data_t w);
    int n = 0;
    for (int i = 0; i < `LANE_DATA_WIDTH; i++) begin
      n += int'(w[i]);
    end
    return n;
  endfunction

  // Whole instruction at acceptance, element by element
  task automatic record_instr(instr_t ins, data_t scalar, logic [`LANE_ELEMS-1:0] mask);
    data_t   a;
    data_t   b;
    exp_wr_t w;
    for (int e = 0; e < `LANE_ELEMS; e++) begin
      case (ins.funct3)
        OPIVX:   a = scalar;
        OPIVI:   a = data_t'(ins.vs1_imm);
        default: a = model_q[ins.vs1_imm][e];
      endcase
      b = model_q[ins.vs2][e];
      if (ins.vm || mask[e]) begin
        w.addr = ins.vd;
        w.elem = elem_idx_t'(e);
        w.data = expected_result(ins.funct6, a, b);
        exp_q.push_back(w);
        model_q[ins.vd][e] = w.data;
      end
    end
  endtask

  task automatic check_write();
    exp_wr_t w;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Unexpected write strobe to v%0d element %0d during %0s",
               vd_addr_i, vd_elem_i, cur_name);
    end else begin
      w = exp_q.pop_front();
      if (vd_addr_i !== w.addr) begin
        errors++;
        $display("Fail %0s: vd_addr_o expected %0d actual %0d", cur_name, w.addr, vd_addr_i);
      end
      if (vd_elem_i !== w.elem) begin
        errors++;
        $display("Fail %0s: vd_elem_o expected %0d actual %0d", cur_name, w.elem, vd_elem_i);
      end
      if (vd_wdata_i !== w.data) begin
        errors++;
        $display("Fail %0s: vd_wdata_o expected %08h actual %08h",
                 cur_name, w.data, vd_wdata_i);
      end
      sbit_exp = count_ones(w.data);
      sbit_due = 1'b1;
      writes++;
    end
  endtask

  ////////////////////////////////////////
  // Sampling at the falling edge
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!resetn_i) begin
      for (int r = 0; r < `LANE_REG_NUM; r++) begin
        for (int e = 0; e < `LANE_ELEMS; e++) begin
          model_q[r][e] = '0;
        end
      end
      exp_q.delete();
      sbit_due = 1'b0;
    end else begin
      // Count from the previous write
      if (sbit_due) begin
        if (int'(sbit_cnt_i) != sbit_exp) begin
          errors++;
          $display("Fail %0s: sbit_cnt_o expected %0d actual %0d",
                   cur_name, sbit_exp, sbit_cnt_i);
        end
        sbit_due = 1'b0;
      end
      if (vd_wr_en_i) begin
        check_write();
      end
      if (instr_valid_i && ready_i) begin
        cur_name = test_name_i;
        record_instr(instr_i, rs1_i, mask_bits_i);
      end
    end
    pending = exp_q.size();
  end

endmodule

// ==== tb/lane_tb.sv ====
// Lane testbench top: clock, reset, stimulus table, DUT, monitor and checker bind

`timescale 1ns/1ps
`include "lane_defines.svh"

module lane_tb;
  import lane_pkg::*;

  localparam int num_rows      = 20;
  localparam int ready_timeout = 20;

  logic                              clk;
  logic                              resetn;
  logic                              instr_valid;
  instr_t                            instr;
  data_t                             rs1;
  logic [`LANE_ELEMS-1:0]            mask_bits;
  logic                              ready;
  logic                              vd_wr_en;
  reg_addr_t                         vd_addr;
  elem_idx_t                         vd_elem;
  data_t                             vd_wdata;
  logic [$clog2(`LANE_DATA_WIDTH):0] sbit_cnt;
  logic [8*12-1:0]                   cur_name;
  int                                mon_errors;
  int                                mon_pending;
  int                                mon_writes;

  // Stimulus table
  logic [8*12-1:0]        row_name  [num_rows];
  instr_t                 row_instr [num_rows];
  data_t                  row_rs1   [num_rows];
  logic [`LANE_ELEMS-1:0] row_mask  [num_rows];
  int                     row_cnt = 0;

  int seed = 49315;
  int seq_errors = 0;
  bit timed_out = 1'b0;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  lane_top u_lane_top (
    .clk_i         (clk),
    .resetn_i      (resetn),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .rs1_i         (rs1),
    .mask_bits_i   (mask_bits),
    .ready_o       (ready),
    .vd_wr_en_o    (vd_wr_en),
    .vd_addr_o     (vd_addr),
    .vd_elem_o     (vd_elem),
    .vd_wdata_o    (vd_wdata),
    .sbit_cnt_o    (sbit_cnt)
  );

  lane_monitor u_monitor (
    .clk_i         (clk),
    .resetn_i      (resetn),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .rs1_i         (rs1),
    .mask_bits_i   (mask_bits),
    .ready_i       (ready),
    .vd_wr_en_i    (vd_wr_en),
    .vd_addr_i     (vd_addr),
    .vd_elem_i     (vd_elem),
    .vd_wdata_i    (vd_wdata),
    .sbit_cnt_i    (sbit_cnt),
    .test_name_i   (cur_name),
    .err_cnt_o     (mon_errors),
    .pending_o     (mon_pending),
    .wr_cnt_o      (mon_writes)
  );

  bind lane_top lane_checker u_checker (
    .clk_i         (clk_i),
    .resetn_i      (resetn_i),
    .instr_valid_i (instr_valid_i),
    .ready_i       (ready_o),
    .vd_wr_en_i    (vd_wr_en_o),
    .sbit_cnt_i    (sbit_cnt_o)
  );

  ////////////////////////////////////////
  // Table helpers
  ////////////////////////////////////////

  function automatic instr_t encode(funct6_t op, logic vm, int vs2, int vs1_imm,
                                    funct3_t form, int vd);
    instr_t ins;
    ins.funct6  = op;
    ins.vm      = vm;
    ins.vs2     = reg_addr_t'(vs2);
    ins.vs1_imm = vs1_imm[`LANE_IMM_WIDTH-1:0];
    ins.funct3  = form;
    ins.vd      = reg_addr_t'(vd);
    return ins;
  endfunction

  task automatic add_row(input logic [8*12-1:0] name, input instr_t ins,
                         input logic [`LANE_ELEMS-1:0] mask);
    row_name[row_cnt]  = name;
    row_instr[row_cnt] = ins;
    row_rs1[row_cnt]   = $random(seed);
    row_mask[row_cnt]  = mask;
    row_cnt++;
  endtask

  task automatic build_table();
    // Scalar loads, then one masked load for element variety
    add_row("mv_x_v1", encode(VMV, 1'b1, 0, 0, OPIVX, 1), 4'b0000);
    add_row("mv_x_v2", encode(VMV, 1'b1, 0, 0, OPIVX, 2), 4'b0000);
    add_row("mv_x_v3", encode(VMV, 1'b1, 0, 0, OPIVX, 3), 4'b0000);
    add_row("mv_mask_v4", encode(VMV, 1'b0, 0, 0, OPIVX, 4), 4'b0101);
    add_row("add_vv", encode(VADD, 1'b1, 1, 2, OPIVV, 5), 4'b0000);
    add_row("sub_vv", encode(VSUB, 1'b1, 1, 2, OPIVV, 6), 4'b0000);
    add_row("rsub_vv", encode(VRSUB, 1'b1, 1, 2, OPIVV, 7), 4'b0000);
    add_row("and_vv", encode(VAND, 1'b1, 1, 2, OPIVV, 8), 4'b0000);
    add_row("or_vv", encode(VOR, 1'b1, 1, 2, OPIVV, 9), 4'b0000);
    add_row("xor_vv", encode(VXOR, 1'b1, 1, 2, OPIVV, 10), 4'b0000);
    add_row("minu_vv", encode(VMINU, 1'b1, 1, 3, OPIVV, 11), 4'b0000);
    add_row("maxu_vv", encode(VMAXU, 1'b1, 4, 3, OPIVV, 12), 4'b0000);
    add_row("add_vi", encode(VADD, 1'b1, 4, 19, OPIVI, 13), 4'b0000);
    add_row("rsub_vi", encode(VRSUB, 1'b1, 2, 31, OPIVI, 14), 4'b0000);
    add_row("and_vi", encode(VAND, 1'b1, 3, 22, OPIVI, 18), 4'b0000);
    // Partial overwrite, then copy back to expose kept elements
    add_row("add_mask", encode(VADD, 1'b0, 5, 1, OPIVV, 5), 4'b1010);
    add_row("mv_back", encode(VMV, 1'b1, 0, 5, OPIVV, 15), 4'b0000);
    add_row("mask_none", encode(VXOR, 1'b0, 1, 0, OPIVX, 16), 4'b0000);
    add_row("mv_none", encode(VMV, 1'b1, 0, 16, OPIVV, 17), 4'b0000);
    add_row("add_x_mask", encode(VADD, 1'b0, 13, 0, OPIVX, 19), 4'b0110);
  endtask

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  task automatic wait_ready(output bit ok);
    int n = 0;
    while (!ready && n < ready_timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = ready;
  endtask

  task automatic apply_row(input int r, output bit ok);
    wait_ready(ok);
    if (ok) begin
      cur_name    = row_name[r];
      instr_valid = 1'b1;
      instr       = row_instr[r];
      rs1         = row_rs1[r];
      mask_bits   = row_mask[r];
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
      if (ready) begin
        seq_errors++;
        $display("ready_o stayed high after %0s was accepted", row_name[r]);
      end
      @(posedge clk);
      #1;
      // Strobe while busy must be dropped
      instr_valid = 1'b1;
      instr       = encode(VMV, 1'b1, 0, 0, OPIVX, 31);
      rs1         = 32'hffff_ffff;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
    end
  endtask

  initial begin
    bit ok;
    instr_valid = 1'b0;
    instr       = '0;
    rs1         = '0;
    mask_bits   = '0;
    cur_name    = "reset";
    resetn      = 1'b0;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    resetn = 1'b1;
    if (!ready || vd_wr_en || sbit_cnt != '0) begin
      seq_errors++;
      $display("Outputs not at their reset values after reset release");
    end
    for (int r = 0; r < row_cnt && !timed_out; r++) begin
      apply_row(r, ok);
      if (!ok) begin
        timed_out = 1'b1;
        $display("Timeout: ready_o did not return before row %0s", row_name[r]);
      end
    end
    if (!timed_out) begin
      wait_ready(ok);
      if (!ok) begin
        timed_out = 1'b1;
        $display("Timeout: ready_o did not return after the last row");
      end
    end
    // One cycle for the last set-bit count
    repeat (2) @(posedge clk);
    if (mon_pending != 0) begin
      seq_errors++;
      $display("%0d expected writes never appeared", mon_pending);
    end
    $display("Errors: %0d monitor, %0d sequence, %0d assertion, %0d writes checked",
             mon_errors, seq_errors, u_lane_top.u_checker.fail_cnt, mon_writes);
    if (!timed_out && mon_errors == 0 && seq_errors == 0 &&
        u_lane_top.u_checker.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+hw
hw/lane_pkg.sv
hw/lane_stage_if.sv
hw/lane_issue.sv
hw/lane_vrf.sv
hw/lane_alu.sv
hw/lane_writeback.sv
hw/lane_top.sv
tb/lane_checker.sv
tb/lane_monitor.sv
tb/lane_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the lane testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module lane_tb \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vlane_tb > sim.log 2>&1 || { cat sim.log; echo "Simulation stopped on an error"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Test failed"; exit 1; } || exit 0
